/* hdl/rv_exec_defs.svh */
// RV32I execute stage constants
// Word width, major opcodes, ALU operation codes and branch funct3 values
`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// ----------------------------------------------------------------------
// Word width
// ----------------------------------------------------------------------
`define XLEN 32

// ----------------------------------------------------------------------
// Major opcodes, instr[6:0]
// ----------------------------------------------------------------------
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// ----------------------------------------------------------------------
// ALU operations, {instr[30], funct3}
// ----------------------------------------------------------------------
`define ALU_ADD  4'b0000
`define ALU_SUB  4'b1000
`define ALU_SLL  4'b0001
`define ALU_SLT  4'b0010
`define ALU_SLTU 4'b0011
`define ALU_XOR  4'b0100
`define ALU_SRL  4'b0101
`define ALU_SRA  4'b1101
`define ALU_OR   4'b0110
`define ALU_AND  4'b0111

// Branch conditions, funct3 of BRANCH
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`endif

/* hdl/rv_exec_pkg.sv */
// RV32I execute stage types
// Word, instruction, opcode and ALU operation types plus instruction classes
`include "rv_exec_defs.svh"

package rv_exec_pkg;

    // Data and address word
    typedef logic [`XLEN-1:0] word_t;
    // Raw 32-bit instruction
    typedef logic [31:0]      instr_t;
    // Major opcode field
    typedef logic [6:0]       opcode_t;
    // ALU operation, bit 30 then funct3
    typedef logic [3:0]       alu_op_t;

    // Execute classes derived from the opcode
    typedef enum logic [2:0] {
        alu_reg,
        alu_imm,
        mem_addr,
        branch,
        jump_pc,
        jump_reg,
        upper_pc,
        illegal
    } exec_class_t;

endpackage

/* hdl/alu.sv */
// RV32I integer ALU
// Add, subtract, shifts, set-less-than and bitwise logic on 32-bit words
`timescale 1ns/100ps
`include "rv_exec_defs.svh"

module alu import rv_exec_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   r
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount is the low five bits only
    assign shamt = b[4:0];

    // Compare results for SLT and SLTU
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    always_comb begin
        case (op)
            `ALU_ADD: begin
                r = a + b;
            end
            `ALU_SUB: begin
                r = a - b;
            end
            `ALU_SLL: begin
                r = a << shamt;
            end
            `ALU_SLT: begin
                r = {{(`XLEN-1){1'b0}}, lt_signed};
            end
            `ALU_SLTU: begin
                r = {{(`XLEN-1){1'b0}}, lt_unsigned};
            end
            `ALU_XOR: begin
                r = a ^ b;
            end
            `ALU_SRL: begin
                r = a >> shamt;
            end
            // Arithmetic shift keeps the sign
            `ALU_SRA: begin
                r = word_t'($signed(a) >>> shamt);
            end
            `ALU_OR: begin
                r = a | b;
            end
            `ALU_AND: begin
                r = a & b;
            end
            // Undefined codes
            default: begin
                r = '0;
            end
        endcase
    end

endmodule

/* hdl/executer.sv */
// RV32I execute logic
// Classifies the instruction, picks ALU operands and resolves branches and jumps
`timescale 1ns/100ps
`include "rv_exec_defs.svh"

module executer import rv_exec_pkg::*; (
    input  instr_t instr,
    input  word_t  pc,
    input  word_t  rs1,
    input  word_t  rs2,
    input  word_t  imm,
    output word_t  result,
    output logic   branch_taken,
    output logic   link_sel
);

    opcode_t     opcode;
    logic [2:0]  funct3;
    exec_class_t ex_class;
    logic        sel_pc;
    logic        sel_imm;
    alu_op_t     alu_op;
    word_t       alu_a;
    word_t       alu_b;
    word_t       alu_r;
    logic        cond_true;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // ------------------------------------------------------------------
    // Instruction class
    // ------------------------------------------------------------------
    always_comb begin
        case (opcode)
            `OP_REG:    ex_class = alu_reg;
            `OP_IMM:    ex_class = alu_imm;
            // LUI arrives with rs1 forced to zero
            `OP_LUI,
            `OP_LOAD,
            `OP_STORE:  ex_class = mem_addr;
            `OP_BRANCH: ex_class = branch;
            `OP_JAL:    ex_class = jump_pc;
            `OP_JALR:   ex_class = jump_reg;
            `OP_AUIPC:  ex_class = upper_pc;
            default:    ex_class = illegal;
        endcase
    end

    // ------------------------------------------------------------------
    // Operand and operation select
    // ------------------------------------------------------------------
    // Default is rs1 + imm
    always_comb begin
        sel_pc  = 1'b0;
        sel_imm = 1'b1;
        alu_op  = `ALU_ADD;
        case (ex_class)
            alu_reg: begin
                sel_imm = 1'b0;
                alu_op  = {instr[30], funct3};
            end
            alu_imm: begin
                // Bit 30 is part of the immediate except for shifts
                if (funct3[1:0] == 2'b01) begin
                    alu_op = {instr[30], funct3};
                end else begin
                    alu_op = {1'b0, funct3};
                end
            end
            // Targets and AUIPC are pc relative
            branch, jump_pc, upper_pc: begin
                sel_pc = 1'b1;
            end
            illegal: begin
                sel_imm = 1'b0;
            end
            default: begin
            end
        endcase
    end

    assign alu_a = sel_pc  ? pc  : rs1;
    assign alu_b = sel_imm ? imm : rs2;

    // ------------------------------------------------------------------
    // Branch condition
    // ------------------------------------------------------------------
    always_comb begin
        case (funct3)
            `F3_BEQ:  cond_true = (rs1 == rs2);
            `F3_BNE:  cond_true = (rs1 != rs2);
            `F3_BLT:  cond_true = ($signed(rs1) < $signed(rs2));
            `F3_BGE:  cond_true = ($signed(rs1) >= $signed(rs2));
            // Unsigned forms
            `F3_BLTU: cond_true = (rs1 < rs2);
            `F3_BGEU: cond_true = (rs1 >= rs2);
            default:  cond_true = 1'b0;
        endcase
    end

    // Jumps always redirect, branches only on a true condition
    assign link_sel     = (ex_class == jump_pc) || (ex_class == jump_reg);
    assign branch_taken = link_sel || ((ex_class == branch) && cond_true);

    alu alu_i (
        .a  (alu_a),
        .b  (alu_b),
        .op (alu_op),
        .r  (alu_r)
    );

    // JALR target has bit 0 cleared
    assign result = (ex_class == jump_reg) ? {alu_r[`XLEN-1:1], 1'b0} : alu_r;

endmodule

/* hdl/issue_latch.sv */
// Execute stage input register
// Captures one issued instruction with its pc and operands on the issue strobe
`timescale 1ns/100ps

module issue_latch import rv_exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   issue_valid,
    input  instr_t instr,
    input  word_t  pc,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    input  word_t  imm,
    output logic   ex_valid,
    output instr_t ex_instr,
    output word_t  ex_pc,
    output word_t  ex_rs1,
    output word_t  ex_rs2,
    output word_t  ex_imm
);

    // ------------------------------------------------------------------
    // Valid bit
    // ------------------------------------------------------------------
    // One-cycle pulse per issued instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
    end

    // ------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------
    // Loads only on issue, holds the last instruction otherwise
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_instr <= instr;
            ex_pc    <= pc;
            ex_rs1   <= rs1_data;
            ex_rs2   <= rs2_data;
            // Already sign extended by decode
            ex_imm   <= imm;
        end
    end

endmodule

/* hdl/retire_reg.sv */
// Execute stage output register
// Registers the writeback value and raises a redirect for taken branches and jumps
`timescale 1ns/100ps

module retire_reg import rv_exec_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ex_valid,
    input  word_t ex_pc,
    input  word_t alu_result,
    input  logic  branch_taken,
    input  logic  link_sel,
    output logic  wb_valid,
    output word_t wb_data,
    output logic  redirect,
    output word_t redirect_pc
);

    word_t link_addr;
    word_t wb_next;

    // Return address for JAL and JALR
    assign link_addr = ex_pc + word_t'(4);
    assign wb_next   = link_sel ? link_addr : alu_result;

    // ------------------------------------------------------------------
    // Control pulses
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            // One pulse per taken branch or jump
            redirect <= ex_valid && branch_taken;
        end
    end

    // ------------------------------------------------------------------
    // Result payload
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_data     <= wb_next;
            // Target is the ALU sum
            redirect_pc <= alu_result;
        end
    end

endmodule

/* hdl/exec_top.sv */
// RV32I execute stage top level
// Issue latch, combinational execute and retire register, two cycles in total
`timescale 1ns/100ps

module exec_top import rv_exec_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   issue_valid,
    input  instr_t instr,
    input  word_t  pc,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    input  word_t  imm,
    output logic   wb_valid,
    output word_t  wb_data,
    output logic   redirect,
    output word_t  redirect_pc
);

    // Latched instruction
    logic   ex_valid;
    instr_t ex_instr;
    word_t  ex_pc;
    word_t  ex_rs1;
    word_t  ex_rs2;
    word_t  ex_imm;

    // Execute results
    word_t  alu_result;
    logic   branch_taken;
    logic   link_sel;

    // Stage 1
    issue_latch latch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .ex_valid    (ex_valid),
        .ex_instr    (ex_instr),
        .ex_pc       (ex_pc),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_imm      (ex_imm)
    );

    // Combinational execute between the two registers
    executer exec_i (
        .instr        (ex_instr),
        .pc           (ex_pc),
        .rs1          (ex_rs1),
        .rs2          (ex_rs2),
        .imm          (ex_imm),
        .result       (alu_result),
        .branch_taken (branch_taken),
        .link_sel     (link_sel)
    );

    // Stage 2
    retire_reg retire_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .alu_result   (alu_result),
        .branch_taken (branch_taken),
        .link_sel     (link_sel),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

/* verif/exec_tb.sv */
// Testbench for the RV32I execute stage
// Random legal instructions against a reference model, checked at every writeback
`timescale 1ns/100ps
`include "rv_exec_defs.svh"

module exec_tb import rv_exec_pkg::*; ();

    localparam int N_ALU    = 60;
    localparam int N_BRANCH = 72;
    localparam int N_JUMP   = 24;
    localparam int N_ADDR   = 40;
    localparam int N_STREAM = 200;
    localparam int N_RESET  = 30;
    localparam int N_TOTAL  = N_ALU + N_BRANCH + N_JUMP + N_ADDR + N_STREAM + N_RESET;

    // Expected outcome of one instruction
    typedef struct packed {
        word_t wb;
        logic  redir;
        word_t rpc;
    } exp_t;

    logic   clk;
    logic   rst_n;
    logic   issue_valid;
    instr_t instr;
    word_t  pc;
    word_t  rs1_data;
    word_t  rs2_data;
    word_t  imm;
    logic   wb_valid;
    word_t  wb_data;
    logic   redirect;
    word_t  redirect_pc;

    logic [31:0] lfsr;
    exp_t        exp_q[$];
    int          errors;
    int          checks;
    int          test_errors;
    int          test_checks;
    string       test_name;

    exec_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Random source
    // ----------------------------------------------------------------------
    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t sext(input word_t v, input int bits);
        return word_t'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic exp_t ref_model(input instr_t ins, input word_t pc_v, input word_t a,
                                       input word_t b_reg, input word_t imm_v);
        exp_t       e;
        word_t      b;
        logic [4:0] sh;
        logic       lt_s;
        logic       lt_u;
        e    = '0;
        // Register ops and branches use rs2, the rest the immediate
        b    = (ins[6:0] == `OP_REG || ins[6:0] == `OP_BRANCH) ? b_reg : imm_v;
        sh   = b[4:0];
        lt_u = (a < b);
        // Signs differ, the negative one is smaller
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;
        case (ins[6:0])
            `OP_REG, `OP_IMM: begin
                case (ins[14:12])
                    3'b000:  e.wb = (ins[6:0] == `OP_REG && ins[30]) ? a - b : a + b;
                    3'b001:  e.wb = a << sh;
                    3'b010:  e.wb = {31'b0, lt_s};
                    3'b011:  e.wb = {31'b0, lt_u};
                    3'b100:  e.wb = a ^ b;
                    // Fill the vacated top bits with the sign for SRA
                    3'b101:  e.wb = (a >> sh) | ((ins[30] && a[31]) ? ~(32'hffffffff >> sh) : 0);
                    3'b110:  e.wb = a | b;
                    default: e.wb = a & b;
                endcase
            end
            `OP_BRANCH: begin
                case (ins[14:12])
                    `F3_BEQ:  e.redir = (a == b_reg);
                    `F3_BNE:  e.redir = (a != b_reg);
                    `F3_BLT:  e.redir = lt_s;
                    `F3_BGE:  e.redir = !lt_s;
                    `F3_BLTU: e.redir = lt_u;
                    default:  e.redir = !lt_u;
                endcase
                e.wb  = pc_v + imm_v;
                e.rpc = pc_v + imm_v;
            end
            `OP_JAL: begin
                e.wb    = pc_v + 4;
                e.redir = 1'b1;
                e.rpc   = pc_v + imm_v;
            end
            `OP_JALR: begin
                e.wb    = pc_v + 4;
                e.redir = 1'b1;
                e.rpc   = (a + imm_v) & ~32'h1;
            end
            `OP_AUIPC: e.wb = pc_v + imm_v;
            // LOAD, STORE and LUI with zero rs1
            default: e.wb = a + imm_v;
        endcase
        return e;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // Kind 0 ALU, 1 branch, 2 jumps, 3 address and upper, else any
    function automatic opcode_t pick_op(input int kind);
        int n;
        case (kind)
            0:       n = rand_bits(1);
            1:       n = 2;
            2:       n = 3 + rand_bits(1);
            3:       n = 5 + rand_bits(2);
            default: n = rand_bits(32) % 9;
        endcase
        case (n)
            0:       return `OP_REG;
            1:       return `OP_IMM;
            2:       return `OP_BRANCH;
            3:       return `OP_JAL;
            4:       return `OP_JALR;
            5:       return `OP_LOAD;
            6:       return `OP_STORE;
            7:       return `OP_LUI;
            default: return `OP_AUIPC;
        endcase
    endfunction

    // Legal encoding with random fields, issued for one cycle
    task automatic issue_op(input opcode_t op);
        instr_t     ins;
        word_t      a;
        word_t      b;
        word_t      iv;
        word_t      p;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] r1;
        logic [4:0] r2;
        logic       alt;
        p   = rand_bits(30) << 2;
        a   = rand_bits(32);
        // Equal operands one time in four
        b   = (rand_bits(2) == 0) ? a : rand_bits(32);
        f3  = rand_bits(3);
        rd  = rand_bits(5);
        r1  = rand_bits(5);
        r2  = rand_bits(5);
        alt = rand_bits(1);
        iv  = sext(rand_bits(12), 12);
        case (op)
            `OP_REG: begin
                // funct7 bit 30 only for SUB and SRA
                alt = alt && (f3 == 3'b000 || f3 == 3'b101);
                ins = {1'b0, alt, 5'b0, r2, r1, f3, rd, op};
            end
            `OP_IMM: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    iv = {21'b0, alt && (f3 == 3'b101), 5'b0, iv[4:0]};
                end
                ins = {iv[11:0], r1, f3, rd, op};
            end
            `OP_BRANCH: begin
                // funct3 010 and 011 are no branches
                if (f3[2:1] == 2'b01) begin
                    f3 = {2'b10, f3[0]};
                end
                iv  = sext(rand_bits(12) << 1, 13);
                ins = {iv[12], iv[10:5], r2, r1, f3, iv[4:1], iv[11], op};
            end
            `OP_JAL: begin
                iv  = sext(rand_bits(20) << 1, 21);
                ins = {iv[20], iv[10:1], iv[11], iv[19:12], rd, op};
            end
            `OP_JALR: ins = {iv[11:0], r1, 3'b000, rd, op};
            `OP_LOAD: ins = {iv[11:0], r1, 3'b010, rd, op};
            `OP_STORE: ins = {iv[11:5], r2, r1, 3'b010, iv[4:0], op};
            default: begin
                // LUI and AUIPC, decode zeroes rs1 for LUI
                iv  = rand_bits(20) << 12;
                ins = {iv[31:12], rd, op};
                if (op == `OP_LUI) begin
                    a = '0;
                end
            end
        endcase
        issue_valid = 1'b1;
        instr       = ins;
        pc          = p;
        rs1_data    = a;
        rs2_data    = b;
        imm         = iv;
        exp_q.push_back(ref_model(ins, p, a, b, iv));
        @(posedge clk);
        #1;
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    // Fixed two-cycle latency, so the queue is empty three edges after the last issue
    task automatic end_test();
        issue_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d writebacks never arrived", test_name, exp_q.size());
            count_error();
            exp_q.delete();
        end
        $display("test %-8s %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
        repeat (n) issue_op(pick_op(kind));
        end_test();
    endtask

    // Reset with instructions in flight, then a fresh stream
    task automatic reset_test();
        test_name   = "reset";
        test_errors = 0;
        test_checks = 0;
        repeat (N_RESET - 10) issue_op(pick_op(4));
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        // In-flight instructions are lost
        exp_q.delete();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            test_checks++;
            checks++;
            assert (!wb_valid && !redirect) else begin
                $display("reset: output pulse after reset with nothing issued");
                count_error();
            end
        end
        @(posedge clk);
        #1;
        repeat (10) issue_op(pick_op(4));
        end_test();
    endtask

    // ----------------------------------------------------------------------
    // Compare at each writeback, mid-cycle
    // ----------------------------------------------------------------------
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            if (wb_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("%s: wb_valid with no instruction in flight", test_name);
                    count_error();
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    test_checks++;
                    checks++;
                    assert (wb_data == e.wb) else begin
                        $display("** Error %s wb_data: expected %h, actual %h",
                                 test_name, e.wb, wb_data);
                        count_error();
                    end
                    assert (redirect == e.redir) else begin
                        $display("** Error %s redirect: expected %b, actual %b",
                                 test_name, e.redir, redirect);
                        count_error();
                    end
                    if (e.redir) begin
                        assert (redirect_pc == e.rpc) else begin
                            $display("** Error %s redirect_pc: expected %h, actual %h",
                                     test_name, e.rpc, redirect_pc);
                            count_error();
                        end
                    end
                end
            end
        end
    end

    // Watchdog, one cycle per instruction plus reset and drain slack
    initial begin
        #(N_TOTAL * 10 + 1000);
        $display("watchdog: the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        lfsr        = 32'd61997;
        rst_n       = 1'b1;
        issue_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        imm         = '0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        test_checks = 0;
        test_name   = "init";
        #1;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        run_test("alu", 0, N_ALU);
        run_test("branch", 1, N_BRANCH);
        run_test("jump", 2, N_JUMP);
        run_test("addr", 3, N_ADDR);
        run_test("stream", 4, N_STREAM);
        reset_test();
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verif/exec_sva.sv */
// Execute stage port assertions
// Writeback latency, redirect qualification and quiet outputs in reset
`timescale 1ns/100ps

module exec_sva (
    input logic clk,
    input logic rst_n,
    input logic issue_valid,
    input logic wb_valid,
    input logic redirect
);

    // Every issue retires two cycles later
    issue_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> ##2 wb_valid)
        else $error("wb_valid missing two cycles after issue");

    // And no writeback without that issue
    wb_from_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(issue_valid, 2))
        else $error("wb_valid without an issue two cycles before");

    redirect_with_wb: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> wb_valid)
        else $error("redirect without wb_valid");

    // Pulses held low while in reset
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!wb_valid && !redirect))
        else $error("output pulse during reset");

endmodule

bind exec_top exec_sva sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .wb_valid    (wb_valid),
    .redirect    (redirect)
);

/* verilog.f */
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/alu.sv
hdl/executer.sv
hdl/issue_latch.sv
hdl/retire_reg.sv
hdl/exec_top.sv
verif/exec_tb.sv
verif/exec_sva.sv
